//--- source/wh_dma_pkg.sv
// widths, burst length and memory depth of the wormhole DMA endpoint
// header flit, DMA packet and pending-read source types

package wh_dma_pkg;

  localparam int FLIT_WIDTH = 32;
  localparam int ADDR_WIDTH = 16;
  localparam int CORD_WIDTH = 4;
  localparam int CID_WIDTH  = 2;
  localparam int LEN_WIDTH  = 4;

  // data beats per DMA transfer
  localparam int BURST_LEN  = 4;
  localparam int BEAT_WIDTH = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;
  localparam logic [BEAT_WIDTH-1:0] LAST_BEAT = BEAT_WIDTH'(BURST_LEN - 1);

  // backend depth in words
  localparam int MEM_WORDS      = 256;
  localparam int MEM_ADDR_WIDTH = $clog2(MEM_WORDS);

  localparam int FIFO_DEPTH = 2;

  // response header length counts data flits only
  localparam logic [LEN_WIDTH-1:0] RESP_LEN = LEN_WIDTH'(BURST_LEN);

  localparam int HDR_USED_WIDTH = 2 * CORD_WIDTH + 2 * CID_WIDTH + LEN_WIDTH + 1;

  typedef logic [FLIT_WIDTH-1:0] flit_t;

  // cord sits in the low bits of the flit
  typedef struct packed {
    logic [FLIT_WIDTH-HDR_USED_WIDTH-1:0] unused;
    logic                                 write_not_read;
    logic [CID_WIDTH-1:0]                 src_cid;
    logic [CORD_WIDTH-1:0]                src_cord;
    logic [CID_WIDTH-1:0]                 cid;
    logic [LEN_WIDTH-1:0]                 len;
    logic [CORD_WIDTH-1:0]                cord;
  } wh_header_t;

  typedef struct packed {
    logic                  write_not_read;
    logic [ADDR_WIDTH-1:0] addr;
  } dma_pkt_t;

  // where a pending read has to be answered
  typedef struct packed {
    logic [CORD_WIDTH-1:0] src_cord;
    logic [CID_WIDTH-1:0]  src_cid;
  } src_info_t;

endpackage

//--- source/wh_flit_fifo.sv
// small circular FIFO with read and write pointers
// payload type is a parameter for flits and pending read sources

`timescale 1ns/10ps

module wh_flit_fifo #(
  parameter type payload_t = wh_dma_pkg::flit_t
  , parameter int depth_p  = wh_dma_pkg::FIFO_DEPTH
) (
  input  logic     clk_i
  , input  logic     reset_i

  , input  payload_t data_i
  , input  logic     v_i
  , output logic     ready_o

  , output payload_t data_o
  , output logic     v_o
  , input  logic     yumi_i
);

  localparam int ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;

  payload_t mem_r [depth_p];

  logic [ptr_width_lp-1:0] rd_ptr_r, rd_ptr_n;
  logic [ptr_width_lp-1:0] wr_ptr_r, wr_ptr_n;
  logic full_r;
  logic empty;
  logic enq, deq;

  // full_r tells empty from full when the pointers are equal
  assign empty   = (rd_ptr_r == wr_ptr_r) & ~full_r;
  assign ready_o = ~full_r;
  assign v_o     = ~empty;
  assign data_o  = mem_r[rd_ptr_r];

  assign enq = v_i & ~full_r;
  assign deq = yumi_i;

  assign wr_ptr_n = (wr_ptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
  assign rd_ptr_n = (rd_ptr_r == ptr_width_lp'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      full_r   <= 1'b0;
    end else begin
      if (enq) begin
        wr_ptr_r <= wr_ptr_n;
      end
      if (deq) begin
        rd_ptr_r <= rd_ptr_n;
      end
      // pointers meet again after a lone write
      if (enq & ~deq) begin
        full_r <= (wr_ptr_n == rd_ptr_r);
      end else if (deq & ~enq) begin
        full_r <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (enq) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  // consumer may only take what is there
  assert property (@(posedge clk_i) disable iff (reset_i) yumi_i |-> v_o);

endmodule

//--- source/wh_to_dma_bridge.sv
// wormhole to cache DMA bridge
// send FSM strips the header and issues DMA packets and evict data
// receive FSM wraps fill data into response packets for the requester

`timescale 1ns/10ps

module wh_to_dma_bridge (
  input  logic                                clk_i
  , input  logic                                reset_i

  // wormhole flits from the input buffer
  , input  wh_dma_pkg::flit_t                   flit_i
  , input  logic                                flit_v_i
  , output logic                                flit_ready_o

  // wormhole flits toward the output buffer
  , output wh_dma_pkg::flit_t                   flit_o
  , output logic                                flit_v_o
  , input  logic                                flit_ready_i

  , output logic                                dma_pkt_write_not_read_o
  , output logic [wh_dma_pkg::ADDR_WIDTH-1:0]   dma_pkt_addr_o
  , output logic                                dma_pkt_v_o
  , input  logic                                dma_pkt_yumi_i

  , output wh_dma_pkg::flit_t                   dma_data_o
  , output logic                                dma_data_v_o
  , input  logic                                dma_data_yumi_i

  , input  wh_dma_pkg::flit_t                   dma_data_i
  , input  logic                                dma_data_v_i
  , output logic                                dma_data_ready_o
);

  typedef enum logic [1:0] {
    send_reset,
    send_ready,
    send_dma_pkt,
    send_evict_data
  } send_state_e;

  typedef enum logic [1:0] {
    recv_reset,
    recv_header,
    recv_fill_data
  } recv_state_e;

  send_state_e send_state_r, send_state_n;
  recv_state_e recv_state_r, recv_state_n;

  logic write_not_read_r, write_not_read_n;
  logic [wh_dma_pkg::BEAT_WIDTH-1:0] send_count_r, send_count_n;
  logic [wh_dma_pkg::BEAT_WIDTH-1:0] recv_count_r, recv_count_n;

  wh_dma_pkg::wh_header_t hdr_in;
  wh_dma_pkg::wh_header_t hdr_out;
  wh_dma_pkg::dma_pkt_t   dma_pkt;

  wh_dma_pkg::src_info_t src_info_li, src_info_lo;
  logic src_fifo_v_li, src_fifo_ready_lo;
  logic src_fifo_v_lo, src_fifo_yumi_li;

  assign hdr_in = flit_i;

  // sources of pending reads in request order
  wh_flit_fifo #(
    .payload_t(wh_dma_pkg::src_info_t)
  ) src_fifo (
    .clk_i   (clk_i)
    , .reset_i (reset_i)
    , .data_i  (src_info_li)
    , .v_i     (src_fifo_v_li)
    , .ready_o (src_fifo_ready_lo)
    , .data_o  (src_info_lo)
    , .v_o     (src_fifo_v_lo)
    , .yumi_i  (src_fifo_yumi_li)
  );

  assign src_info_li.src_cord = hdr_in.src_cord;
  assign src_info_li.src_cid  = hdr_in.src_cid;

  // address flit sits at the buffer head while the packet is offered
  assign dma_pkt.write_not_read = write_not_read_r;
  assign dma_pkt.addr           = flit_i[wh_dma_pkg::ADDR_WIDTH-1:0];

  assign dma_pkt_write_not_read_o = dma_pkt.write_not_read;
  assign dma_pkt_addr_o           = dma_pkt.addr;
  assign dma_data_o               = flit_i;

  always_comb begin
    send_state_n     = send_state_r;
    write_not_read_n = write_not_read_r;
    send_count_n     = send_count_r;
    src_fifo_v_li    = 1'b0;
    flit_ready_o     = 1'b0;
    dma_pkt_v_o      = 1'b0;
    dma_data_v_o     = 1'b0;

    case (send_state_r)
      send_reset: begin
        send_state_n = send_ready;
      end
      // take a header only while there is room to remember its source
      send_ready: begin
        flit_ready_o = src_fifo_ready_lo;
        if (flit_v_i & src_fifo_ready_lo) begin
          write_not_read_n = hdr_in.write_not_read;
          src_fifo_v_li    = ~hdr_in.write_not_read;
          send_state_n     = send_dma_pkt;
        end
      end
      send_dma_pkt: begin
        dma_pkt_v_o  = flit_v_i;
        flit_ready_o = dma_pkt_yumi_i;
        if (dma_pkt_yumi_i) begin
          send_state_n = write_not_read_r ? send_evict_data : send_ready;
        end
      end
      send_evict_data: begin
        dma_data_v_o = flit_v_i;
        flit_ready_o = dma_data_yumi_i;
        if (dma_data_yumi_i) begin
          if (send_count_r == wh_dma_pkg::LAST_BEAT) begin
            send_count_n = '0;
            send_state_n = send_ready;
          end else begin
            send_count_n = send_count_r + 1'b1;
          end
        end
      end
      default: begin
        send_state_n = send_reset;
      end
    endcase
  end

  // response header goes back to the requester of the oldest read
  always_comb begin
    hdr_out          = '0;
    hdr_out.len      = wh_dma_pkg::RESP_LEN;
    hdr_out.cord     = src_info_lo.src_cord;
    hdr_out.cid      = src_info_lo.src_cid;
  end

  always_comb begin
    recv_state_n     = recv_state_r;
    recv_count_n     = recv_count_r;
    flit_v_o         = 1'b0;
    flit_o           = hdr_out;
    dma_data_ready_o = 1'b0;
    src_fifo_yumi_li = 1'b0;

    case (recv_state_r)
      recv_reset: begin
        recv_state_n = recv_header;
      end
      recv_header: begin
        flit_v_o = dma_data_v_i & src_fifo_v_lo;
        if (flit_v_o & flit_ready_i) begin
          src_fifo_yumi_li = 1'b1;
          recv_state_n     = recv_fill_data;
        end
      end
      recv_fill_data: begin
        flit_v_o         = dma_data_v_i;
        flit_o           = dma_data_i;
        dma_data_ready_o = flit_ready_i;
        if (dma_data_v_i & flit_ready_i) begin
          if (recv_count_r == wh_dma_pkg::LAST_BEAT) begin
            recv_count_n = '0;
            recv_state_n = recv_header;
          end else begin
            recv_count_n = recv_count_r + 1'b1;
          end
        end
      end
      default: begin
        recv_state_n = recv_reset;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      send_state_r     <= send_reset;
      recv_state_r     <= recv_reset;
      write_not_read_r <= 1'b0;
      send_count_r     <= '0;
      recv_count_r     <= '0;
    end else begin
      send_state_r     <= send_state_n;
      recv_state_r     <= recv_state_n;
      write_not_read_r <= write_not_read_n;
      send_count_r     <= send_count_n;
      recv_count_r     <= recv_count_n;
    end
  end

  // a write also counts its address flit in len
  assert property (@(posedge clk_i) disable iff (reset_i)
    (send_state_r == send_ready && flit_v_i && flit_ready_o) |->
      (int'(hdr_in.len) == (hdr_in.write_not_read ? wh_dma_pkg::BURST_LEN + 1
                                                  : wh_dma_pkg::BURST_LEN)));

  // offered packet holds until the backend takes it
  assert property (@(posedge clk_i) disable iff (reset_i)
    (dma_pkt_v_o && !dma_pkt_yumi_i) |=> (dma_pkt_v_o && $stable(dma_pkt)));

endmodule

//--- source/dma_mem_backend.sv
// word-addressed on-chip memory behind the cache DMA interface
// serves one read or write burst at a time

`timescale 1ns/10ps

module dma_mem_backend (
  input  logic                              clk_i
  , input  logic                              reset_i

  , input  logic                              dma_pkt_write_not_read_i
  , input  logic [wh_dma_pkg::ADDR_WIDTH-1:0] dma_pkt_addr_i
  , input  logic                              dma_pkt_v_i
  , output logic                              dma_pkt_yumi_o

  // evict data of a write burst
  , input  wh_dma_pkg::flit_t                 dma_data_i
  , input  logic                              dma_data_v_i
  , output logic                              dma_data_yumi_o

  // fill data of a read burst
  , output wh_dma_pkg::flit_t                 dma_data_o
  , output logic                              dma_data_v_o
  , input  logic                              dma_data_ready_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_write,
    st_read
  } state_e;

  state_e state_r, state_n;

  logic [wh_dma_pkg::MEM_ADDR_WIDTH-1:0] ptr_r, ptr_n;
  logic [wh_dma_pkg::BEAT_WIDTH-1:0]     count_r, count_n;
  logic mem_we;
  logic beat_done;

  wh_dma_pkg::flit_t mem_r [wh_dma_pkg::MEM_WORDS];

  // fill beat is read straight from the array at the word pointer
  assign dma_data_o = mem_r[ptr_r];

  always_comb begin
    state_n         = state_r;
    ptr_n           = ptr_r;
    count_n         = count_r;
    dma_pkt_yumi_o  = 1'b0;
    dma_data_yumi_o = 1'b0;
    dma_data_v_o    = 1'b0;
    mem_we          = 1'b0;
    beat_done       = 1'b0;

    case (state_r)
      st_idle: begin
        dma_pkt_yumi_o = dma_pkt_v_i;
        if (dma_pkt_v_i) begin
          // word index of the byte address wraps at the memory depth
          ptr_n   = dma_pkt_addr_i[wh_dma_pkg::MEM_ADDR_WIDTH+1:2];
          count_n = '0;
          state_n = dma_pkt_write_not_read_i ? st_write : st_read;
        end
      end
      st_write: begin
        dma_data_yumi_o = dma_data_v_i;
        mem_we          = dma_data_v_i;
        beat_done       = dma_data_v_i;
      end
      st_read: begin
        dma_data_v_o = 1'b1;
        beat_done    = dma_data_ready_i;
      end
      default: begin
        state_n = st_idle;
      end
    endcase

    if (beat_done) begin
      ptr_n = ptr_r + 1'b1;
      if (count_r == wh_dma_pkg::LAST_BEAT) begin
        count_n = '0;
        state_n = st_idle;
      end else begin
        count_n = count_r + 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= st_idle;
      ptr_r   <= '0;
      count_r <= '0;
    end else begin
      state_r <= state_n;
      ptr_r   <= ptr_n;
      count_r <= count_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_we) begin
      mem_r[ptr_r] <= dma_data_i;
    end
  end

  // evict data only follows an accepted write packet
  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == st_idle) |-> !dma_data_v_i);

endmodule

//--- source/wh_dma_subsystem.sv
// wormhole memory endpoint with input buffer, bridge, memory backend and output buffer
// ready/valid link on both sides

`timescale 1ns/10ps

module wh_dma_subsystem (
  input  logic              clk_i
  , input  logic              reset_i

  , input  wh_dma_pkg::flit_t link_data_i
  , input  logic              link_v_i
  , output logic              link_ready_o

  , output wh_dma_pkg::flit_t link_data_o
  , output logic              link_v_o
  , input  logic              link_ready_i
);

  wh_dma_pkg::flit_t in_data, out_data;
  logic in_v, in_ready, in_yumi;
  logic out_v, out_ready, out_yumi;

  logic pkt_write_not_read;
  logic [wh_dma_pkg::ADDR_WIDTH-1:0] pkt_addr;
  logic pkt_v, pkt_yumi;

  wh_dma_pkg::flit_t evict_data, fill_data;
  logic evict_v, evict_yumi;
  logic fill_v, fill_ready;

  // buffers take yumi while the bridge and the link speak ready
  assign in_yumi  = in_v & in_ready;
  assign out_yumi = link_v_o & link_ready_i;

  wh_flit_fifo #(
    .payload_t(wh_dma_pkg::flit_t)
  ) in_fifo (
    .clk_i   (clk_i)
    , .reset_i (reset_i)
    , .data_i  (link_data_i)
    , .v_i     (link_v_i)
    , .ready_o (link_ready_o)
    , .data_o  (in_data)
    , .v_o     (in_v)
    , .yumi_i  (in_yumi)
  );

  wh_to_dma_bridge bridge (
    .clk_i                      (clk_i)
    , .reset_i                    (reset_i)
    , .flit_i                     (in_data)
    , .flit_v_i                   (in_v)
    , .flit_ready_o               (in_ready)
    , .flit_o                     (out_data)
    , .flit_v_o                   (out_v)
    , .flit_ready_i               (out_ready)
    , .dma_pkt_write_not_read_o   (pkt_write_not_read)
    , .dma_pkt_addr_o             (pkt_addr)
    , .dma_pkt_v_o                (pkt_v)
    , .dma_pkt_yumi_i             (pkt_yumi)
    , .dma_data_o                 (evict_data)
    , .dma_data_v_o               (evict_v)
    , .dma_data_yumi_i            (evict_yumi)
    , .dma_data_i                 (fill_data)
    , .dma_data_v_i               (fill_v)
    , .dma_data_ready_o           (fill_ready)
  );

  dma_mem_backend backend (
    .clk_i                      (clk_i)
    , .reset_i                    (reset_i)
    , .dma_pkt_write_not_read_i   (pkt_write_not_read)
    , .dma_pkt_addr_i             (pkt_addr)
    , .dma_pkt_v_i                (pkt_v)
    , .dma_pkt_yumi_o             (pkt_yumi)
    , .dma_data_i                 (evict_data)
    , .dma_data_v_i               (evict_v)
    , .dma_data_yumi_o            (evict_yumi)
    , .dma_data_o                 (fill_data)
    , .dma_data_v_o               (fill_v)
    , .dma_data_ready_i           (fill_ready)
  );

  wh_flit_fifo #(
    .payload_t(wh_dma_pkg::flit_t)
  ) out_fifo (
    .clk_i   (clk_i)
    , .reset_i (reset_i)
    , .data_i  (out_data)
    , .v_i     (out_v)
    , .ready_o (out_ready)
    , .data_o  (link_data_o)
    , .v_o     (link_v_o)
    , .yumi_i  (out_yumi)
  );

endmodule

//--- tb/tb_wh_dma_subsystem.sv
// testbench for the wormhole DMA endpoint
// reference memory, expected response queue and checking assertions

`timescale 1ns/10ps

module tb_wh_dma_subsystem;

  localparam int FLIT_W      = wh_dma_pkg::FLIT_WIDTH;
  localparam int ADDR_W      = wh_dma_pkg::ADDR_WIDTH;
  localparam int LEN_W       = wh_dma_pkg::LEN_WIDTH;
  localparam int BURST       = wh_dma_pkg::BURST_LEN;
  localparam int WORDS       = wh_dma_pkg::MEM_WORDS;
  localparam int SEND_LIMIT  = 200;
  localparam int DRAIN_LIMIT = 4000;

  logic clk;
  logic reset;
  wh_dma_pkg::flit_t in_data;
  wh_dma_pkg::flit_t out_data;
  logic in_v;
  logic in_ready;
  logic out_v;
  logic out_ready = 1'b1;
  logic ready_gaps = 1'b0;

  wh_dma_pkg::flit_t ref_mem [WORDS];
  wh_dma_pkg::flit_t expected_q [$];
  logic [ADDR_W-1:0] written_q [$];

  // head_idx walks along the append-only expected_q
  int head_idx = 0;
  int exp_pending = 0;
  wh_dma_pkg::flit_t exp_head = '0;
  logic took_r;

  logic [31:0] rnd;
  logic [ADDR_W-1:0] addr;
  int waited;

  wh_dma_subsystem DUT (
    .clk_i          (clk)
    , .reset_i      (reset)
    , .link_data_i  (in_data)
    , .link_v_i     (in_v)
    , .link_ready_o (in_ready)
    , .link_data_o  (out_data)
    , .link_v_o     (out_v)
    , .link_ready_i (out_ready)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_on_failure(input string what);
    $display("%s", what);
    $display("tests failed");
    $fatal(1);
  endtask

  function automatic wh_dma_pkg::flit_t make_request_header(
    input logic                              write_not_read,
    input logic [wh_dma_pkg::CORD_WIDTH-1:0] src_cord,
    input logic [wh_dma_pkg::CID_WIDTH-1:0]  src_cid
  );
    wh_dma_pkg::wh_header_t hdr;
    logic [31:0] dest;
    dest = $urandom;
    hdr = '0;
    hdr.cord = dest[3:0];
    hdr.cid = dest[5:4];
    // a write counts its address flit in len
    hdr.len = write_not_read ? LEN_W'(BURST + 1) : LEN_W'(BURST);
    hdr.src_cord = src_cord;
    hdr.src_cid = src_cid;
    hdr.write_not_read = write_not_read;
    return hdr;
  endfunction

  // response goes back to the requester with zero source fields
  function automatic wh_dma_pkg::flit_t make_response_header(
    input logic [wh_dma_pkg::CORD_WIDTH-1:0] src_cord,
    input logic [wh_dma_pkg::CID_WIDTH-1:0]  src_cid
  );
    wh_dma_pkg::wh_header_t hdr;
    hdr = '0;
    hdr.cord = src_cord;
    hdr.cid = src_cid;
    hdr.len = LEN_W'(BURST);
    return hdr;
  endfunction

  // starts on a falling edge and returns one falling edge after the transfer
  task automatic send_flit(input wh_dma_pkg::flit_t flit);
    int tries;
    tries = 0;
    while (!in_ready) begin
      if (tries == SEND_LIMIT) begin
        stop_on_failure("link_ready_o stayed low too long while sending a flit");
      end
      @(negedge clk);
      tries++;
    end
    in_data = flit;
    in_v = 1'b1;
    @(negedge clk);
    in_v = 1'b0;
    in_data = '0;
  endtask

  task automatic write_burst(input logic [ADDR_W-1:0] byte_addr);
    logic [31:0] src;
    wh_dma_pkg::flit_t data;
    int k;
    src = $urandom;
    send_flit(make_request_header(1'b1, src[3:0], src[5:4]));
    send_flit(FLIT_W'(byte_addr));
    for (k = 0; k < BURST; k++) begin
      data = $urandom;
      // beat k lands at word A/4 + k modulo the memory depth
      ref_mem[(int'(byte_addr >> 2) + k) % WORDS] = data;
      send_flit(data);
    end
    written_q.push_back(byte_addr);
  endtask

  task automatic read_burst(
    input logic [ADDR_W-1:0]                 byte_addr,
    input logic [wh_dma_pkg::CORD_WIDTH-1:0] src_cord,
    input logic [wh_dma_pkg::CID_WIDTH-1:0]  src_cid
  );
    int k;
    expected_q.push_back(make_response_header(src_cord, src_cid));
    for (k = 0; k < BURST; k++) begin
      expected_q.push_back(ref_mem[(int'(byte_addr >> 2) + k) % WORDS]);
    end
    send_flit(make_request_header(1'b0, src_cord, src_cid));
    send_flit(FLIT_W'(byte_addr));
  endtask

  task automatic wait_drained();
    int tries;
    tries = 0;
    while (head_idx != expected_q.size()) begin
      if (tries == DRAIN_LIMIT) begin
        stop_on_failure("read responses did not arrive before the timeout");
      end
      @(negedge clk);
      tries++;
    end
  endtask

  always @(posedge clk) begin
    if (reset) begin
      took_r <= 1'b0;
    end else begin
      took_r <= out_v & out_ready;
    end
  end

  // step past a delivered flit and refresh the head seen by the assertions
  always @(negedge clk) begin
    if (took_r) begin
      head_idx = head_idx + 1;
    end
    exp_pending = expected_q.size() - head_idx;
    if (exp_pending > 0) begin
      exp_head = expected_q[head_idx];
    end else begin
      exp_head = '0;
    end
  end

  always @(negedge clk) begin
    if (ready_gaps) begin
      out_ready = ($urandom_range(3) != 0);
    end else begin
      out_ready = 1'b1;
    end
  end

  // a flit may only leave while a response is owed
  assert property (@(posedge clk) disable iff (reset) out_v |-> (exp_pending > 0))
    else stop_on_failure("an output flit appeared while no read response was pending");

  assert property (@(posedge clk) disable iff (reset)
    (out_v && out_ready) |-> (out_data == exp_head))
    else stop_on_failure($sformatf("Error: time %0t link_data_o got %h expected %h",
                                   $time, $sampled(out_data), $sampled(exp_head)));

  assert property (@(posedge clk) disable iff (reset)
    (out_v && !out_ready) |=> (out_v && $stable(out_data)))
    else stop_on_failure("link_data_o changed or dropped while link_ready_i was low");

  initial begin
    void'($urandom(95));
    reset = 1'b1;
    in_v = 1'b0;
    in_data = '0;
    repeat (10) @(negedge clk);
    reset = 1'b0;

    waited = 0;
    while (!in_ready) begin
      if (waited == SEND_LIMIT) begin
        stop_on_failure("link_ready_o did not rise after reset");
      end
      @(negedge clk);
      waited++;
    end

    // write then read back one burst-aligned block
    rnd = $urandom;
    addr = {rnd[15:4], 4'b0000};
    write_burst(addr);
    read_burst(addr, rnd[19:16], rnd[21:20]);
    wait_drained();

    // writes alone must stay silent on the output
    repeat (4) begin
      rnd = $urandom;
      write_burst({rnd[15:2], 2'b00});
    end
    repeat (30) @(negedge clk);

    // two reads back to back from different requesters
    rnd = $urandom;
    read_burst(written_q[0], rnd[3:0], rnd[5:4]);
    read_burst(written_q[written_q.size() - 1], rnd[3:0] + 4'd1, rnd[5:4]);
    wait_drained();

    // mixed traffic with the output stalling at random
    ready_gaps = 1'b1;
    repeat (16) begin
      rnd = $urandom;
      if (rnd[0]) begin
        write_burst({rnd[15:2], 2'b00});
      end else begin
        read_burst(written_q[$urandom_range(written_q.size() - 1)], rnd[19:16], rnd[21:20]);
      end
      repeat (rnd[25:24]) @(negedge clk);
    end

    waited = 0;
    while (head_idx != expected_q.size() && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    // quiet period so a stray flit is still caught
    repeat (20) @(negedge clk);
    if (head_idx == expected_q.size()) begin
      $display("all tests passed");
      $finish;
    end else begin
      stop_on_failure("read responses were still missing at the end of the run");
    end
  end

endmodule

//--- wh_dma_subsystem.f
source/wh_dma_pkg.sv
source/wh_flit_fifo.sv
source/wh_to_dma_bridge.sv
source/dma_mem_backend.sv
source/wh_dma_subsystem.sv
tb/tb_wh_dma_subsystem.sv

//--- Makefile
TOP = tb_wh_dma_subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --timing -j 0 -f wh_dma_subsystem.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "all tests passed"

lint:
	verilator --lint-only -Wall --timing -f wh_dma_subsystem.f --top-module wh_dma_subsystem

clean:
	rm -rf obj_dir
